/* project.f */
+incdir+rtl
rtl/cmd_pkg.sv
rtl/payload_capture.sv
rtl/byte_fifo.sv
rtl/frame_parser.sv
rtl/key_debounce.sv
rtl/reg_display.sv
rtl/cmd_rx_top.sv
verification/cmd_rx_checker.sv
verification/cmd_rx_tb.sv

/* Bender.yml */
package:
  name: cmd_rx

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/cmd_pkg.sv
      - rtl/payload_capture.sv
      - rtl/byte_fifo.sv
      - rtl/frame_parser.sv
      - rtl/key_debounce.sv
      - rtl/reg_display.sv
      - rtl/cmd_rx_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verification/cmd_rx_checker.sv
      - verification/cmd_rx_tb.sv

/* verification/cmd_rx_tb.sv */
`include "cmd_cfg.svh"

module cmd_rx_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import cmd_pkg::*;

    localparam int CLK_PERIOD  = 100;
    localparam int NROWS       = 8;
    localparam int MAX_LEN     = 20;
    localparam int GAP         = 30;
    localparam int UPDATE_WAIT = 200;

    logic        sys_clk = 1'b0;
    logic        rst;
    logic        rx_valid;
    logic [7:0]  rx_data;
    logic        rx_last;
    logic [1:0]  key;
    cmd_regs_s   cmd_regs;
    logic        cmd_update;
    logic        frame_ok;
    logic [7:0]  err_cnt;
    logic [31:0] led;
    logic [3:0]  lec;

    cmd_regs_s   exp_regs;
    logic        exp_ok;
    logic [7:0]  exp_err;
    logic [31:0] exp_led;
    logic [3:0]  exp_lec;
    logic        exp_flag;
    logic        disp_chk;
    int          update_cnt;
    int          check_cnt;
    int          error_cnt;
    int          tb_errors;
    int          total_bytes;
    logic [1:0]  page;
    logic [15:0] lfsr;
    logic        table_ready = 1'b0;

    // frame table
    logic [7:0]  row_bytes [NROWS][MAX_LEN];
    int          row_len   [NROWS];
    logic        row_ok    [NROWS];
    logic        row_busy  [NROWS];
    cmd_regs_s   row_exp   [NROWS];
    string       row_name  [NROWS];

    always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

    cmd_rx_top dut0 (
        .sys_clk    (sys_clk),
        .rst        (rst),
        .rx_valid   (rx_valid),
        .rx_data    (rx_data),
        .rx_last    (rx_last),
        .key        (key),
        .cmd_regs   (cmd_regs),
        .cmd_update (cmd_update),
        .frame_ok   (frame_ok),
        .err_cnt    (err_cnt),
        .led        (led),
        .lec        (lec)
    );

    cmd_rx_checker mon0 (
        .sys_clk    (sys_clk),
        .rst        (rst),
        .cmd_regs   (cmd_regs),
        .cmd_update (cmd_update),
        .frame_ok   (frame_ok),
        .err_cnt    (err_cnt),
        .led        (led),
        .lec        (lec),
        .exp_regs   (exp_regs),
        .exp_ok     (exp_ok),
        .exp_err    (exp_err),
        .exp_led    (exp_led),
        .exp_lec    (exp_lec),
        .disp_chk   (disp_chk),
        .update_cnt (update_cnt),
        .check_cnt  (check_cnt),
        .error_cnt  (error_cnt)
    );

    // galois form of x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [7:0] b;
        b = '0;
        for (int k = 0; k < 8; k++) begin
            b    = {b[6:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return b;
    endfunction

    // pages of 55 AA kind_dev info_sr 6B cmd_filt .. cmd_reg7
    function automatic logic [31:0] expected_led(input logic [1:0] p, input cmd_regs_s r);
        logic [95:0] all;
        all = {16'h55AA, r.kind_dev, r.info_sr, 8'h6B, r[55:0]};
        return all[95 - 32 * int'(p) -: 32];
    endfunction

    task automatic set_row(input int i, input string name, input logic [7:0] magic,
                           input logic [7:0] kind, input logic [7:0] word_hi,
                           input int len, input logic ok, input logic busy);
        row_name[i]     = name;
        row_bytes[i][0] = magic;
        row_bytes[i][1] = kind;
        row_bytes[i][2] = word_hi;
        row_len[i]      = len;
        row_ok[i]       = ok;
        row_busy[i]     = busy;
    endtask

    task automatic build_table();
        cmd_regs_s regs;
        regs = '0;
        for (int i = 0; i < NROWS; i++) begin
            for (int j = 0; j < MAX_LEN; j++) begin
                row_bytes[i][j] = rand_byte();
            end
        end
        set_row(0, "config frame", `CMD_FRAME_MAGIC, KIND_CONFIG, rand_byte(), 11, 1, 0);
        set_row(1, "write cmd_mix1", `CMD_FRAME_MAGIC, KIND_REG_WRITE, 8'd2, 4, 1, 0);
        set_row(2, "bad magic", `CMD_FRAME_MAGIC ^ 8'hFF, KIND_REG_WRITE, 8'd0, 4, 0, 0);
        set_row(3, "length mismatch", `CMD_FRAME_MAGIC, KIND_REG_WRITE, 8'd3, 5, 0, 0);
        set_row(4, "reg_addr 7", `CMD_FRAME_MAGIC, KIND_REG_WRITE, 8'd7, 4, 0, 0);
        set_row(5, "overflow", `CMD_FRAME_MAGIC, KIND_CONFIG, rand_byte(), 20, 0, 0);
        set_row(6, "write cmd_reg7", `CMD_FRAME_MAGIC, KIND_REG_WRITE, 8'd6, 4, 1, 0);
        set_row(7, "dropped while busy", `CMD_FRAME_MAGIC, KIND_REG_WRITE, 8'd0, 4, 0, 1);
        // expected register bank after each row
        for (int i = 0; i < NROWS; i++) begin
            if (row_ok[i] && row_bytes[i][1] == KIND_CONFIG) begin
                for (int j = 2; j < 11; j++) begin
                    regs = {regs[63:0], row_bytes[i][j]};
                end
            end else if (row_ok[i]) begin
                regs[55 - 8 * int'(row_bytes[i][2]) -: 8] = row_bytes[i][3];
            end
            row_exp[i]  = regs;
            total_bytes = total_bytes + row_len[i];
        end
    endtask

    task automatic wait_cycle();
        @(posedge sys_clk);
        #5;
    endtask

    task automatic send_frame(input int i);
        for (int j = 0; j < row_len[i]; j++) begin
            wait_cycle();
            rx_valid = 1'b1;
            rx_data  = row_bytes[i][j];
            rx_last  = (j == row_len[i] - 1);
        end
    endtask

    task automatic wait_updates(input int target, input string name);
        int n;
        n = 0;
        while (update_cnt < target && n < UPDATE_WAIT) begin
            wait_cycle();
            n++;
        end
        if (update_cnt < target) begin
            $display("no cmd_update within %0d cycles for %s", UPDATE_WAIT, name);
            tb_errors++;
        end
    endtask

    task automatic check_display();
        exp_led  = expected_led(page, exp_regs);
        exp_lec  = {exp_flag, 3'b001 << page};
        disp_chk = 1'b1;
        wait_cycle();
        disp_chk = 1'b0;
    endtask

    task automatic press_key(input logic up);
        key = up ? 2'b01 : 2'b10;
        repeat (20) wait_cycle();
        key = 2'b11;
        repeat (20) wait_cycle();
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (error_cnt + tb_errors == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: failed", name);
        end
    endtask

    initial begin : main_seq
        int first_err;
        int exp_updates;
        logic [4:0] key_seq;
        rst         = 1'b1;
        rx_valid    = 1'b0;
        rx_data     = '0;
        rx_last     = 1'b0;
        key         = 2'b11;
        disp_chk    = 1'b0;
        exp_regs    = '0;
        exp_ok      = 1'b0;
        exp_err     = '0;
        exp_flag    = 1'b0;
        exp_led     = '0;
        exp_lec     = '0;
        tb_errors   = 0;
        total_bytes = 0;
        page        = 2'd0;
        lfsr        = 16'd56875;
        exp_updates = 0;
        // up, up, up (wraps), down (wraps), down
        key_seq     = 5'b00111;
        build_table();
        table_ready = 1'b1;
        repeat (3) @(posedge sys_clk);
        #5;
        rst = 1'b0;

        first_err = error_cnt + tb_errors;
        check_display();
        report_test("reset values", first_err);

        for (int i = 0; i < NROWS; i++) begin
            if (!row_busy[i]) begin
                first_err = error_cnt + tb_errors;
                exp_regs  = row_exp[i];
                exp_ok    = row_ok[i];
                exp_flag  = ~row_ok[i];
                exp_updates++;
                if (!row_ok[i]) begin
                    exp_err = exp_err + 8'd1;
                end
            end
            send_frame(i);
            // next frame follows with no gap
            if (i + 1 < NROWS && row_busy[i + 1]) begin
                continue;
            end
            wait_cycle();
            rx_valid = 1'b0;
            rx_last  = 1'b0;
            wait_updates(exp_updates, row_name[i]);
            repeat (GAP) wait_cycle();
            if (update_cnt != exp_updates) begin
                $display("saw %0d frame updates but expected %0d after %s",
                         update_cnt, exp_updates, row_name[i]);
                tb_errors++;
            end
            check_display();
            report_test(row_name[i], first_err);
        end

        for (int k = 0; k < 5; k++) begin
            first_err = error_cnt + tb_errors;
            press_key(key_seq[k]);
            if (key_seq[k]) begin
                page = 2'((int'(page) + 1) % 3);
            end else begin
                page = 2'((int'(page) + 2) % 3);
            end
            check_display();
            report_test($sformatf("key %s to page %0d", key_seq[k] ? "up" : "down", page),
                        first_err);
        end

        $display("checks %0d, errors %0d", check_cnt, error_cnt + tb_errors);
        if (error_cnt + tb_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        wait (table_ready);
        #((total_bytes * 4 + 2000) * CLK_PERIOD);
        $display("run did not finish within %0d cycles", total_bytes * 4 + 2000);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* verification/cmd_rx_checker.sv */
module cmd_rx_checker (
    input  logic               sys_clk,
    input  logic               rst,
    input  cmd_pkg::cmd_regs_s cmd_regs,
    input  logic               cmd_update,
    input  logic               frame_ok,
    input  logic [7:0]         err_cnt,
    input  logic [31:0]        led,
    input  logic [3:0]         lec,
    input  cmd_pkg::cmd_regs_s exp_regs,
    input  logic               exp_ok,
    input  logic [7:0]         exp_err,
    input  logic [31:0]        exp_led,
    input  logic [3:0]         exp_lec,
    input  logic               disp_chk,
    output int                 update_cnt,
    output int                 check_cnt,
    output int                 error_cnt
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        update_cnt = 0;
        check_cnt  = 0;
        error_cnt  = 0;
    end

    task automatic check_value(input string name, input logic [71:0] got,
                               input logic [71:0] exp);
        check_cnt++;
        if (got !== exp) begin
            error_cnt++;
            $display("Fail %s: got %0h expected %0h at %0t", name, got, exp, $time);
        end
    endtask

    // outputs settle well before the falling edge
    always @(negedge sys_clk) begin
        if (!rst) begin
            if (cmd_update) begin
                update_cnt++;
                check_value("frame_ok", frame_ok, exp_ok);
                check_value("cmd_regs", cmd_regs, exp_regs);
                check_value("err_cnt", err_cnt, exp_err);
            end
            if (disp_chk) begin
                check_value("cmd_regs", cmd_regs, exp_regs);
                check_value("err_cnt", err_cnt, exp_err);
                check_value("led", led, exp_led);
                check_value("lec", lec, exp_lec);
            end
        end
    end

endmodule

/* rtl/cmd_rx_top.sv */
module cmd_rx_top (
    input  logic               sys_clk,
    input  logic               rst,
    input  logic               rx_valid,
    input  logic [7:0]         rx_data,
    input  logic               rx_last,
    input  logic [1:0]         key,
    output cmd_pkg::cmd_regs_s cmd_regs,
    output logic               cmd_update,
    output logic               frame_ok,
    output logic [7:0]         err_cnt,
    output logic [31:0]        led,
    output logic [3:0]         lec
);
    import cmd_pkg::*;

    logic        wr_en;
    logic [7:0]  din;
    logic        rd_en;
    logic [7:0]  dout;
    logic        frame_req;
    logic        frame_ack;
    frame_desc_s frame_desc;
    logic        page_up;
    logic        page_down;

    payload_capture u_capture (
        .sys_clk    (sys_clk),
        .rst        (rst),
        .rx_valid   (rx_valid),
        .rx_data    (rx_data),
        .rx_last    (rx_last),
        .wr_en      (wr_en),
        .din        (din),
        .frame_req  (frame_req),
        .frame_desc (frame_desc),
        .frame_ack  (frame_ack)
    );

    byte_fifo u_fifo (
        .sys_clk (sys_clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .din     (din),
        .rd_en   (rd_en),
        .dout    (dout)
    );

    frame_parser u_parser (
        .sys_clk    (sys_clk),
        .rst        (rst),
        .frame_req  (frame_req),
        .frame_desc (frame_desc),
        .frame_ack  (frame_ack),
        .rd_en      (rd_en),
        .dout       (dout),
        .cmd_regs   (cmd_regs),
        .cmd_update (cmd_update),
        .frame_ok   (frame_ok),
        .err_cnt    (err_cnt)
    );

    // key[1] pages up, key[0] pages down
    key_debounce u_key_up (
        .sys_clk (sys_clk),
        .rst     (rst),
        .key     (key[1]),
        .press   (page_up)
    );

    key_debounce u_key_down (
        .sys_clk (sys_clk),
        .rst     (rst),
        .key     (key[0]),
        .press   (page_down)
    );

    reg_display u_display (
        .sys_clk    (sys_clk),
        .rst        (rst),
        .page_up    (page_up),
        .page_down  (page_down),
        .cmd_regs   (cmd_regs),
        .frame_ok   (frame_ok),
        .cmd_update (cmd_update),
        .led        (led),
        .lec        (lec)
    );

endmodule

/* rtl/reg_display.sv */
module reg_display (
    input  logic               sys_clk,
    input  logic               rst,
    input  logic               page_up,
    input  logic               page_down,
    input  cmd_pkg::cmd_regs_s cmd_regs,
    input  logic               frame_ok,
    input  logic               cmd_update,
    output logic [31:0]        led,
    output logic [3:0]         lec
);
    logic [1:0] page;
    logic       err_flag;
    logic [7:0] disp [12];
    logic [3:0] base;

    assign disp[0]  = 8'h55;
    assign disp[1]  = 8'hAA;
    assign disp[2]  = cmd_regs.kind_dev;
    assign disp[3]  = cmd_regs.info_sr;
    assign disp[4]  = 8'h6B;
    assign disp[5]  = cmd_regs.cmd_filt;
    assign disp[6]  = cmd_regs.cmd_mix0;
    assign disp[7]  = cmd_regs.cmd_mix1;
    assign disp[8]  = cmd_regs.cmd_reg4;
    assign disp[9]  = cmd_regs.cmd_reg5;
    assign disp[10] = cmd_regs.cmd_reg6;
    assign disp[11] = cmd_regs.cmd_reg7;

    // four registers per page, lowest index on the top byte
    assign base = {page, 2'b00};
    assign led  = {disp[base], disp[base + 4'd1], disp[base + 4'd2], disp[base + 4'd3]};
    assign lec  = {err_flag, page == 2'd2, page == 2'd1, page == 2'd0};

    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            page     <= 2'd0;
            err_flag <= 1'b0;
        end else begin
            if (page_up) begin
                page <= (page == 2'd2) ? 2'd0 : page + 2'd1;
            end else if (page_down) begin
                page <= (page == 2'd0) ? 2'd2 : page - 2'd1;
            end
            // last frame outcome
            if (cmd_update) begin
                err_flag <= ~frame_ok;
            end
        end
    end

endmodule

/* rtl/key_debounce.sv */
`include "cmd_cfg.svh"

module key_debounce (
    input  logic sys_clk,
    input  logic rst,
    input  logic key,
    output logic press
);
    localparam int STABLE = `CMD_DEBOUNCE_CYCLES;
    localparam int CW     = $clog2(STABLE + 1);

    logic [1:0]    sync;
    logic          filt;
    logic [CW-1:0] cnt;

    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            // keys idle high
            sync  <= 2'b11;
            filt  <= 1'b1;
            cnt   <= '0;
            press <= 1'b0;
        end else begin
            sync  <= {sync[0], key};
            press <= 1'b0;
            if (sync[1] == filt) begin
                cnt <= '0;
            end else if (cnt == CW'(STABLE - 1)) begin
                cnt   <= '0;
                filt  <= sync[1];
                press <= ~sync[1];
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

/* rtl/frame_parser.sv */
`include "cmd_cfg.svh"

module frame_parser (
    input  logic                 sys_clk,
    input  logic                 rst,
    input  logic                 frame_req,
    input  cmd_pkg::frame_desc_s frame_desc,
    output logic                 frame_ack,
    output logic                 rd_en,
    input  logic [7:0]           dout,
    output cmd_pkg::cmd_regs_s   cmd_regs,
    output logic                 cmd_update,
    output logic                 frame_ok,
    output logic [7:0]           err_cnt
);
    import cmd_pkg::*;

    localparam logic [4:0] CFG_LEN = 5'd11;
    localparam logic [4:0] WR_LEN  = 5'd4;
    localparam logic [7:0] MAX_REG = 8'd6;

    typedef enum logic [1:0] {ST_IDLE, ST_READ, ST_COMMIT, ST_ACK} state_e;

    state_e      state;
    logic [4:0]  rd_left;
    logic        rd_vld;
    logic [4:0]  idx;
    logic [7:0]  magic;
    frame_kind_e kind;
    cmd_word_u   cmd_word;
    logic [7:0]  cfg_bytes [7];
    logic        frame_good;
    cmd_regs_s   next_regs;

    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            state      <= ST_IDLE;
            rd_en      <= 1'b0;
            rd_left    <= '0;
            rd_vld     <= 1'b0;
            idx        <= '0;
            frame_ack  <= 1'b0;
            cmd_update <= 1'b0;
            frame_ok   <= 1'b0;
            err_cnt    <= '0;
            cmd_regs   <= '0;
        end else begin
            rd_vld     <= rd_en;
            cmd_update <= 1'b0;
            frame_ok   <= 1'b0;
            case (state)
                ST_IDLE: begin
                    idx <= '0;
                    if (frame_req) begin
                        rd_en   <= 1'b1;
                        rd_left <= frame_desc.len;
                        state   <= ST_READ;
                    end
                end
                ST_READ: begin
                    // one byte requested per cycle until len is reached
                    if (rd_en) begin
                        rd_left <= rd_left - 5'd1;
                        rd_en   <= (rd_left != 5'd1);
                    end
                    if (rd_vld) begin
                        idx <= idx + 5'd1;
                        if (idx == frame_desc.len - 5'd1) begin
                            state <= ST_COMMIT;
                        end
                    end
                end
                ST_COMMIT: begin
                    frame_ack  <= 1'b1;
                    cmd_update <= 1'b1;
                    frame_ok   <= frame_good;
                    if (frame_good) begin
                        cmd_regs <= next_regs;
                    end else if (err_cnt != 8'hFF) begin
                        err_cnt <= err_cnt + 8'd1;
                    end
                    state <= ST_ACK;
                end
                ST_ACK: begin
                    if (!frame_req) begin
                        frame_ack <= 1'b0;
                        state     <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // frame bytes by position, anything past byte 10 is ignored
    always_ff @(posedge sys_clk) begin
        if (state == ST_READ && rd_vld) begin
            case (idx)
                5'd0: magic <= dout;
                5'd1: kind <= frame_kind_e'(dout);
                5'd2: cmd_word.cfg.kind_dev <= dout;
                5'd3: cmd_word.cfg.info_sr <= dout;
                default: begin
                    if (idx <= 5'd10) begin
                        cfg_bytes[3'(idx - 5'd4)] <= dout;
                    end
                end
            endcase
        end
    end

    // lengths of 4 or 11 guarantee bytes 0 to 3 belong to this frame
    always_comb begin
        frame_good = 1'b0;
        if (!frame_desc.ovf && magic == `CMD_FRAME_MAGIC) begin
            case (kind)
                KIND_CONFIG: frame_good = (frame_desc.len == CFG_LEN);
                KIND_REG_WRITE: begin
                    frame_good = (frame_desc.len == WR_LEN) &&
                                 (cmd_word.wr.reg_addr <= MAX_REG);
                end
                default: frame_good = 1'b0;
            endcase
        end
    end

    always_comb begin
        next_regs = cmd_regs;
        if (kind == KIND_CONFIG) begin
            next_regs.kind_dev = cmd_word.cfg.kind_dev;
            next_regs.info_sr  = cmd_word.cfg.info_sr;
            next_regs.cmd_filt = cfg_bytes[0];
            next_regs.cmd_mix0 = cfg_bytes[1];
            next_regs.cmd_mix1 = cfg_bytes[2];
            next_regs.cmd_reg4 = cfg_bytes[3];
            next_regs.cmd_reg5 = cfg_bytes[4];
            next_regs.cmd_reg6 = cfg_bytes[5];
            next_regs.cmd_reg7 = cfg_bytes[6];
        end else begin
            case (cmd_word.wr.reg_addr)
                8'd0: next_regs.cmd_filt = cmd_word.wr.reg_val;
                8'd1: next_regs.cmd_mix0 = cmd_word.wr.reg_val;
                8'd2: next_regs.cmd_mix1 = cmd_word.wr.reg_val;
                8'd3: next_regs.cmd_reg4 = cmd_word.wr.reg_val;
                8'd4: next_regs.cmd_reg5 = cmd_word.wr.reg_val;
                8'd5: next_regs.cmd_reg6 = cmd_word.wr.reg_val;
                8'd6: next_regs.cmd_reg7 = cmd_word.wr.reg_val;
                default: ;
            endcase
        end
    end

endmodule

/* rtl/byte_fifo.sv */
`include "cmd_cfg.svh"

module byte_fifo (
    input  logic       sys_clk,
    input  logic       rst,
    input  logic       wr_en,
    input  logic [7:0] din,
    input  logic       rd_en,
    output logic [7:0] dout
);
    localparam int DEPTH = `CMD_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    logic [7:0]    mem [DEPTH];
    logic [AW-1:0] wptr;
    logic [AW-1:0] rptr;

    // wrap explicitly so depth need not be a power of two
    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
        return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            wptr <= '0;
            rptr <= '0;
        end else begin
            if (wr_en) begin
                wptr <= next_ptr(wptr);
            end
            if (rd_en) begin
                rptr <= next_ptr(rptr);
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (wr_en) begin
            mem[wptr] <= din;
        end
        // data shows up the cycle after rd_en
        if (rd_en) begin
            dout <= mem[rptr];
        end
    end

endmodule

/* rtl/payload_capture.sv */
`include "cmd_cfg.svh"

module payload_capture (
    input  logic                 sys_clk,
    input  logic                 rst,
    input  logic                 rx_valid,
    input  logic [7:0]           rx_data,
    input  logic                 rx_last,
    output logic                 wr_en,
    output logic [7:0]           din,
    output logic                 frame_req,
    output cmd_pkg::frame_desc_s frame_desc,
    input  logic                 frame_ack
);
    localparam logic [4:0] DEPTH = 5'(`CMD_FIFO_DEPTH);

    logic [4:0] byte_cnt;
    logic       ovf;
    logic       mid_frame;
    logic       dropping;
    logic       discard;
    logic       room;

    // a frame is kept or dropped as a whole, decided on its first byte
    assign discard = mid_frame ? dropping : (frame_req | frame_ack);
    assign room    = (byte_cnt < DEPTH);

    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            wr_en     <= 1'b0;
            frame_req <= 1'b0;
            byte_cnt  <= '0;
            ovf       <= 1'b0;
            mid_frame <= 1'b0;
            dropping  <= 1'b0;
        end else begin
            wr_en <= 1'b0;
            // release once the parser has drained the frame
            if (frame_req && frame_ack) begin
                frame_req <= 1'b0;
            end
            if (rx_valid) begin
                if (!discard) begin
                    if (room) begin
                        wr_en    <= 1'b1;
                        byte_cnt <= byte_cnt + 5'd1;
                    end else begin
                        ovf <= 1'b1;
                    end
                end
                if (rx_last) begin
                    mid_frame <= 1'b0;
                    dropping  <= 1'b0;
                    byte_cnt  <= '0;
                    ovf       <= 1'b0;
                    if (!discard) begin
                        frame_req <= 1'b1;
                    end
                end else begin
                    mid_frame <= 1'b1;
                    dropping  <= discard;
                end
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        din <= rx_data;
        if (rx_valid && rx_last && !discard) begin
            frame_desc.len <= room ? byte_cnt + 5'd1 : byte_cnt;
            frame_desc.ovf <= ovf | ~room;
        end
    end

endmodule

/* rtl/cmd_pkg.sv */
package cmd_pkg;

    typedef enum logic [7:0] {
        KIND_CONFIG    = 8'h00,
        KIND_REG_WRITE = 8'h01
    } frame_kind_e;

    // goes along with each captured frame
    typedef struct packed {
        logic [4:0] len;
        logic       ovf;
    } frame_desc_s;

    typedef struct packed {
        logic [7:0] kind_dev;
        logic [7:0] info_sr;
    } cfg_hdr_s;

    typedef struct packed {
        logic [7:0] reg_addr;
        logic [7:0] reg_val;
    } reg_wr_s;

    // frame bytes 2 and 3, read by frame kind
    typedef union packed {
        cfg_hdr_s cfg;
        reg_wr_s  wr;
    } cmd_word_u;

    typedef struct packed {
        logic [7:0] kind_dev;
        logic [7:0] info_sr;
        logic [7:0] cmd_filt;
        logic [7:0] cmd_mix0;
        logic [7:0] cmd_mix1;
        logic [7:0] cmd_reg4;
        logic [7:0] cmd_reg5;
        logic [7:0] cmd_reg6;
        logic [7:0] cmd_reg7;
    } cmd_regs_s;

endpackage

/* rtl/cmd_cfg.svh */
`ifndef CMD_CFG_SVH
`define CMD_CFG_SVH

// buffer depth in bytes, must stay below 32
`define CMD_FIFO_DEPTH 16

// first byte of every command frame
`define CMD_FRAME_MAGIC 8'hA5

// stable cycles before a key change is taken
`define CMD_DEBOUNCE_CYCLES 8

`endif
